// File: src/fm_buf_pkg.sv
package fm_buf_pkg;

    // lane and bank geometry
    localparam int DATA_WIDTH = 16;
    localparam int PARA_Y     = 3;
    localparam int DEPTH      = 256;
    localparam int ADDR_WIDTH = 8;

    // all-ones exponent marks infinity
    localparam logic [4:0] FP16_EXP_INF = 5'd31;

    // float16 fields, msb first
    typedef struct packed {
        logic       sign;
        logic [4:0] exponent;
        logic [9:0] mantissa;
    } fp16_fields_t;

    // raw view for storage, field view for arithmetic
    typedef union packed {
        logic [DATA_WIDTH-1:0] raw;
        fp16_fields_t          f;
    } fp16_t;

    // one stored row, lane PARA_Y-1 in the top bits
    typedef fp16_t [PARA_Y-1:0] fm_row_t;

    typedef enum logic [1:0] {
        OP_WRITE     = 2'd0,
        OP_ADD_WRITE = 2'd1,
        OP_ZERO_FILL = 2'd2
    } fm_op_e;

    // row command, end_addr only matters for zero fill
    typedef struct packed {
        fm_op_e                op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [ADDR_WIDTH-1:0] end_addr;
        fm_row_t               row;
    } fm_cmd_t;

    // read request
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
    } fm_rd_req_t;

endpackage

// File: src/fp16_lane_adder.sv
`timescale 1ns/100ps

module fp16_lane_adder
    import fm_buf_pkg::*;
(
    input  logic  clk,
    input  fp16_t a,
    input  fp16_t b,
    output fp16_t sum
);

    // operand classes
    logic a_zero;
    logic b_zero;
    logic a_inf;
    logic b_inf;
    // magnitude ordering
    logic        a_larger;
    fp16_t       hi_op;
    fp16_t       lo_op;
    logic [4:0]  exp_diff;
    // mantissas with hidden bit
    logic [10:0] hi_m;
    logic [10:0] lo_m;
    logic [10:0] lo_sh;
    // datapath results
    logic [11:0] mag_sum;
    logic [10:0] mag_diff;
    logic [10:0] norm_diff;
    logic [3:0]  lead_zeros;
    logic [5:0]  add_exp;
    logic signed [6:0] sub_exp;
    fp16_t       res;

    // exponent 0 flushes to zero, 31 is infinity
    assign a_zero = (a.f.exponent == 5'd0);
    assign b_zero = (b.f.exponent == 5'd0);
    assign a_inf  = (a.f.exponent == FP16_EXP_INF);
    assign b_inf  = (b.f.exponent == FP16_EXP_INF);

    // larger magnitude goes to hi side
    assign a_larger = {a.f.exponent, a.f.mantissa} >= {b.f.exponent, b.f.mantissa};
    assign hi_op    = a_larger ? a : b;
    assign lo_op    = a_larger ? b : a;
    assign exp_diff = hi_op.f.exponent - lo_op.f.exponent;

    assign hi_m  = {1'b1, hi_op.f.mantissa};
    assign lo_m  = {1'b1, lo_op.f.mantissa};
    // alignment drops shifted-out bits
    assign lo_sh = lo_m >> exp_diff;

    assign mag_sum  = {1'b0, hi_m} + {1'b0, lo_sh};
    assign mag_diff = hi_m - lo_sh;

    // distance of the leading one from bit 10
    always_comb begin
        lead_zeros = 4'd0;
        for (int i = 0; i <= 10; i++) begin
            if (mag_diff[i]) begin
                lead_zeros = 4'(10 - i);
            end
        end
    end

    assign norm_diff = mag_diff << lead_zeros;
    // carry out bumps the exponent by one
    assign add_exp   = {1'b0, hi_op.f.exponent} + {5'd0, mag_sum[11]};
    assign sub_exp   = $signed({2'b00, hi_op.f.exponent}) - $signed({3'b000, lead_zeros});

    always_comb begin
        res = '0;
        if (a_inf || b_inf) begin
            res.f.exponent = FP16_EXP_INF;
            // opposing infinities resolve to +inf
            if (a_inf && b_inf && (a.f.sign != b.f.sign)) begin
                res.f.sign = 1'b0;
            end else begin
                res.f.sign = a_inf ? a.f.sign : b.f.sign;
            end
        end else if (a_zero && b_zero) begin
            res = '0;
        end else if (a_zero) begin
            res = b;
        end else if (b_zero) begin
            res = a;
        end else if (a.f.sign == b.f.sign) begin
            res.f.sign = hi_op.f.sign;
            if (add_exp >= 6'd31) begin
                // saturate
                res.f.exponent = FP16_EXP_INF;
            end else begin
                res.f.exponent = add_exp[4:0];
                res.f.mantissa = mag_sum[11] ? mag_sum[10:1] : mag_sum[9:0];
            end
        end else if (mag_diff == 11'd0) begin
            // exact cancel gives +0
            res = '0;
        end else begin
            res.f.sign = hi_op.f.sign;
            if (sub_exp >= 7'sd1) begin
                res.f.exponent = sub_exp[4:0];
                res.f.mantissa = norm_diff[9:0];
            end
            // else underflow leaves signed zero
        end
    end

    always_ff @(posedge clk) begin
        sum <= res;
    end

endmodule

// File: src/fill_addr_counter.sv
`timescale 1ns/100ps

module fill_addr_counter
    import fm_buf_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load,
    input  logic [ADDR_WIDTH-1:0] start,
    input  logic [ADDR_WIDTH-1:0] end_addr,
    input  logic                  step,
    output logic [ADDR_WIDTH-1:0] addr,
    output logic                  last
);

    // exclusive end of the current range
    logic [ADDR_WIDTH-1:0] end_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr  <= '0;
            end_q <= '0;
        end else if (load) begin
            addr  <= start;
            end_q <= end_addr;
        end else if (step) begin
            addr <= addr + 1'b1;
        end
    end

    // one extra bit so address 255 plus one does not wrap
    // also high right after loading an empty range
    assign last = ({1'b0, addr} + 9'd1) >= {1'b0, end_q};

endmodule

// File: src/fm_row_bank.sv
`timescale 1ns/100ps

module fm_row_bank
    import fm_buf_pkg::*;
(
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  fm_row_t               wr_row,
    input  logic                  rd_en,
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    output fm_row_t               rd_row,
    output logic                  rd_valid,
    input  logic                  acc_rd_en,
    input  logic [ADDR_WIDTH-1:0] acc_addr,
    output fm_row_t               acc_row,
    input  logic                  rst_n
);

    // row storage
    fm_row_t mem [DEPTH];

    // same-cycle read of a written row sees old data
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_row;
        end
        // external read port
        if (rd_en) begin
            rd_row <= mem[rd_addr];
        end
        // accumulate read for the adders
        if (acc_rd_en) begin
            acc_row <= mem[acc_addr];
        end
    end

    // valid follows rd_en by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

endmodule

// File: src/fm_buf_ctrl.sv
`timescale 1ns/100ps

module fm_buf_ctrl
    import fm_buf_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmd_valid,
    input  fm_cmd_t               cmd,
    output logic                  cmd_ready,
    output logic                  fill_load,
    output logic [ADDR_WIDTH-1:0] fill_start,
    output logic [ADDR_WIDTH-1:0] fill_end,
    output logic                  fill_step,
    input  logic [ADDR_WIDTH-1:0] fill_addr,
    input  logic                  fill_last,
    output logic                  acc_rd_en,
    output logic [ADDR_WIDTH-1:0] acc_addr,
    input  fm_row_t               sum_row,
    output fm_row_t               add_a_row,
    output logic                  wr_en,
    output logic [ADDR_WIDTH-1:0] wr_addr,
    output fm_row_t               wr_row
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACC_WAIT,
        ST_ACC_WRITE,
        ST_FILL
    } ctrl_state_e;

    ctrl_state_e           state;
    logic                  accept;
    logic [ADDR_WIDTH-1:0] held_addr;
    fm_row_t               held_row;

    // commands only taken in idle
    assign cmd_ready = (state == ST_IDLE);
    assign accept    = cmd_valid && cmd_ready;

    // counter bounds come straight from the command
    assign fill_start = cmd.addr;
    assign fill_end   = cmd.end_addr;
    assign fill_load  = accept && (cmd.op == OP_ZERO_FILL);
    assign fill_step  = (state == ST_FILL);

    // stored row read on the transfer edge
    assign acc_rd_en = accept && (cmd.op == OP_ADD_WRITE);
    assign acc_addr  = cmd.addr;
    assign add_a_row = held_row;

    // write source select
    always_comb begin
        wr_en   = 1'b0;
        wr_addr = cmd.addr;
        wr_row  = cmd.row;
        case (state)
            ST_IDLE: begin
                wr_en = accept && (cmd.op == OP_WRITE);
            end
            ST_ACC_WRITE: begin
                wr_en   = 1'b1;
                wr_addr = held_addr;
                wr_row  = sum_row;
            end
            ST_FILL: begin
                wr_en   = 1'b1;
                wr_addr = fill_addr;
                wr_row  = '0;
            end
            default: begin
                // acc_wait, adders busy
                wr_en = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept && (cmd.op == OP_ADD_WRITE)) begin
                        state <= ST_ACC_WAIT;
                    end else if (fill_load && (cmd.end_addr > cmd.addr)) begin
                        // empty range never leaves idle
                        state <= ST_FILL;
                    end
                end
                ST_ACC_WAIT:  state <= ST_ACC_WRITE;
                ST_ACC_WRITE: state <= ST_IDLE;
                ST_FILL: begin
                    if (fill_last) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // hold addend and target for the read-modify-write
    always_ff @(posedge clk) begin
        if (accept) begin
            held_addr <= cmd.addr;
            held_row  <= cmd.row;
        end
    end

endmodule

// File: src/fm_buf_top.sv
`timescale 1ns/100ps

module fm_buf_top
    import fm_buf_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cmd_valid,
    input  fm_cmd_t    cmd,
    output logic       cmd_ready,
    input  logic       rd_en,
    input  fm_rd_req_t rd_req,
    output fm_row_t    rd_data,
    output logic       rd_valid
);

    // ctrl to counter
    logic                  fill_load;
    logic [ADDR_WIDTH-1:0] fill_start;
    logic [ADDR_WIDTH-1:0] fill_end;
    logic                  fill_step;
    logic [ADDR_WIDTH-1:0] fill_addr;
    logic                  fill_last;
    // ctrl to bank
    logic                  acc_rd_en;
    logic [ADDR_WIDTH-1:0] acc_addr;
    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;
    fm_row_t               wr_row;
    // accumulate path
    fm_row_t               acc_row;
    fm_row_t               add_a_row;
    fm_row_t               sum_row;

    fm_buf_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_ready  (cmd_ready),
        .fill_load  (fill_load),
        .fill_start (fill_start),
        .fill_end   (fill_end),
        .fill_step  (fill_step),
        .fill_addr  (fill_addr),
        .fill_last  (fill_last),
        .acc_rd_en  (acc_rd_en),
        .acc_addr   (acc_addr),
        .sum_row    (sum_row),
        .add_a_row  (add_a_row),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_row     (wr_row)
    );

    fill_addr_counter u_fill_cnt (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (fill_load),
        .start    (fill_start),
        .end_addr (fill_end),
        .step     (fill_step),
        .addr     (fill_addr),
        .last     (fill_last)
    );

    fm_row_bank u_bank (
        .clk       (clk),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_row    (wr_row),
        .rd_en     (rd_en),
        .rd_addr   (rd_req.addr),
        .rd_row    (rd_data),
        .rd_valid  (rd_valid),
        .acc_rd_en (acc_rd_en),
        .acc_addr  (acc_addr),
        .acc_row   (acc_row),
        .rst_n     (rst_n)
    );

    // one adder per lane
    for (genvar i = 0; i < PARA_Y; i++) begin : g_lane
        fp16_lane_adder u_add (
            .clk (clk),
            .a   (add_a_row[i]),
            .b   (acc_row[i]),
            .sum (sum_row[i])
        );
    end

endmodule

// File: testbench/fm_buf_model.svh
`ifndef FM_BUF_MODEL_SVH
`define FM_BUF_MODEL_SVH

// shadow of the bank, updated at command acceptance
fm_row_t shadow [DEPTH];
int      checks;
int      errors;

// float16 add with flush to zero, truncation and saturation
function automatic fp16_t fp16_add(input fp16_t a, input fp16_t b);
    fp16_t r;
    bit    a_first;
    bit    s_hi;
    int    e_hi;
    int    e_lo;
    int    m_hi;
    int    m_lo;
    int    m;
    int    e;
    r = '0;
    // any infinity wins, opposing ones give +inf
    if (a.f.exponent == 5'd31 || b.f.exponent == 5'd31) begin
        r.f.exponent = 5'd31;
        if (a.f.exponent == 5'd31 && b.f.exponent == 5'd31) begin
            r.f.sign = a.f.sign & b.f.sign;
        end else begin
            r.f.sign = (a.f.exponent == 5'd31) ? a.f.sign : b.f.sign;
        end
        return r;
    end
    // exponent zero is zero, subnormals too
    if (a.f.exponent == 5'd0 && b.f.exponent == 5'd0) begin
        return r;
    end
    if (a.f.exponent == 5'd0) begin
        return b;
    end
    if (b.f.exponent == 5'd0) begin
        return a;
    end
    // larger magnitude first, hidden bit restored
    a_first = (a.raw[14:0] >= b.raw[14:0]);
    s_hi    = a_first ? a.f.sign : b.f.sign;
    e_hi    = a_first ? a.f.exponent : b.f.exponent;
    e_lo    = a_first ? b.f.exponent : a.f.exponent;
    m_hi    = 1024 + (a_first ? a.f.mantissa : b.f.mantissa);
    m_lo    = 1024 + (a_first ? b.f.mantissa : a.f.mantissa);
    // bits shifted out are lost
    m_lo    = m_lo >> (e_hi - e_lo);
    e       = e_hi;
    if (a.f.sign == b.f.sign) begin
        m = m_hi + m_lo;
        if (m >= 2048) begin
            m = m >> 1;
            e = e + 1;
        end
        if (e >= 31) begin
            r.f.sign     = s_hi;
            r.f.exponent = 5'd31;
            return r;
        end
    end else begin
        m = m_hi - m_lo;
        // exact cancel is +0
        if (m == 0) begin
            return r;
        end
        while (m < 1024) begin
            m = m << 1;
            e = e - 1;
        end
        // underflow keeps only the sign
        if (e < 1) begin
            r.f.sign = s_hi;
            return r;
        end
    end
    r.f.sign     = s_hi;
    r.f.exponent = e[4:0];
    r.f.mantissa = m[9:0];
    return r;
endfunction

// effect of one accepted command on the shadow
function automatic void apply_cmd(input fm_cmd_t c);
    case (c.op)
        OP_WRITE: begin
            shadow[c.addr] = c.row;
        end
        OP_ADD_WRITE: begin
            for (int i = 0; i < PARA_Y; i++) begin
                shadow[c.addr][i] = fp16_add(c.row[i], shadow[c.addr][i]);
            end
        end
        OP_ZERO_FILL: begin
            // empty range runs no iteration
            for (int a = c.addr; a < c.end_addr; a++) begin
                shadow[a] = '0;
            end
        end
        default: begin
        end
    endcase
endfunction

task automatic check_row(input string name, input fm_row_t exp_row, input fm_row_t act_row);
    checks++;
    if (act_row !== exp_row) begin
        errors++;
        $display("[FAIL] %s expected %h actual %h", name, exp_row, act_row);
    end
endtask

task automatic check_bit(input string name, input logic exp_bit, input logic act_bit);
    checks++;
    if (act_bit !== exp_bit) begin
        errors++;
        $display("[FAIL] %s expected %b actual %b", name, exp_bit, act_bit);
    end
endtask

`endif

// File: testbench/fm_buf_tb.sv
`timescale 1ns/100ps

module fm_buf_tb
    import fm_buf_pkg::*;
();

    localparam int WAIT_LIMIT = 600;

    logic       clk;
    logic       rst_n;
    logic       cmd_valid;
    fm_cmd_t    cmd;
    logic       cmd_ready;
    logic       rd_en;
    fm_rd_req_t rd_req;
    fm_row_t    rd_data;
    logic       rd_valid;

    integer  seed;
    // read issued last cycle
    logic    rd_pending;
    fm_row_t rd_expect;
    string   rd_name;
    // rows still being written by the command in flight
    int      pend_lo;
    int      pend_hi;

    `include "fm_buf_model.svh"

    fm_buf_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .rd_en     (rd_en),
        .rd_req    (rd_req),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid)
    );

    always #10 clk = ~clk;

    task automatic report_counts();
        $display("checks run: %0d, errors: %0d", checks, errors);
    endtask

    task automatic abort_run(input string what);
        errors++;
        $display("timeout: %s", what);
        report_counts();
        $display("Errors found");
        $finish;
    endtask

    // one clock up to the falling edge
    // collects the read issued last cycle
    task automatic clock_cycle();
        @(negedge clk);
        if (rd_pending) begin
            check_bit({rd_name, " rd_valid"}, 1'b1, rd_valid);
            check_row(rd_name, rd_expect, rd_data);
        end else begin
            check_bit("idle rd_valid", 1'b0, rd_valid);
        end
        rd_pending = 1'b0;
        rd_en      = 1'b0;
    endtask

    // expected row captured at request time
    task automatic start_read(input string name, input logic [ADDR_WIDTH-1:0] addr,
                              input fm_row_t exp_row);
        rd_en       = 1'b1;
        rd_req.addr = addr;
        rd_pending  = 1'b1;
        rd_expect   = exp_row;
        rd_name     = name;
    endtask

    function automatic logic [ADDR_WIDTH-1:0] pick_addr();
        int r;
        r = $random(seed);
        return r[ADDR_WIDTH-1:0];
    endfunction

    // exponents 10 to 20 keep values normal
    function automatic fp16_t draw_fp16();
        fp16_t v;
        int    r;
        r            = $random(seed);
        v.f.sign     = r[0];
        v.f.mantissa = r[10:1];
        v.f.exponent = 5'd10 + 5'($unsigned($random(seed)) % 11);
        return v;
    endfunction

    function automatic fm_row_t random_row();
        fm_row_t row;
        for (int i = 0; i < PARA_Y; i++) begin
            row[i] = draw_fp16();
        end
        return row;
    endfunction

    // nonzero and distinct for every address
    function automatic fm_row_t pattern_row(input int a);
        fm_row_t p;
        for (int i = 0; i < PARA_Y; i++) begin
            p[i].raw = {a[0], 5'(12 + i), a[7:0], 2'(i)};
        end
        return p;
    endfunction

    function automatic fm_cmd_t make_cmd(input fm_op_e op, input logic [ADDR_WIDTH-1:0] addr,
                                         input logic [ADDR_WIDTH-1:0] end_addr,
                                         input fm_row_t row);
        fm_cmd_t c;
        c.op       = op;
        c.addr     = addr;
        c.end_addr = end_addr;
        c.row      = row;
        return c;
    endfunction

    // random address moved off rows still in flight
    task automatic random_read(input string name);
        int a;
        a = $unsigned($random(seed)) % DEPTH;
        if (!cmd_ready && a >= pend_lo && a < pend_hi) begin
            a = (pend_hi < DEPTH) ? pend_hi : pend_lo - 1;
        end
        start_read(name, a[ADDR_WIDTH-1:0], shadow[a]);
    endtask

    task automatic wait_idle(input string what);
        int cnt;
        cnt = 0;
        while (!cmd_ready) begin
            if (cnt == WAIT_LIMIT) begin
                abort_run({"cmd_ready stuck low before ", what});
            end
            clock_cycle();
            cnt++;
        end
    endtask

    // holds the command until taken
    // optional reads while stalled
    task automatic issue_cmd(input fm_cmd_t c, input bit read_in_stall);
        int cnt;
        cnt       = 0;
        cmd_valid = 1'b1;
        cmd       = c;
        while (!cmd_ready) begin
            if (cnt == WAIT_LIMIT) begin
                abort_run("command held but never accepted");
            end
            if (read_in_stall && ($random(seed) & 1)) begin
                random_read("stall read");
            end
            clock_cycle();
            cnt++;
        end
        // ready high here means taken on the next rising edge
        apply_cmd(c);
        pend_lo = c.addr;
        pend_hi = (c.op == OP_ZERO_FILL) ? c.end_addr : c.addr + 1;
        clock_cycle();
        cmd_valid = 1'b0;
    endtask

    // ready low for exactly n cycles after the accepting edge
    task automatic verify_stall(input string name, input int n);
        for (int k = 0; k < n; k++) begin
            check_bit({name, " ready low"}, 1'b0, cmd_ready);
            clock_cycle();
        end
        check_bit({name, " ready back"}, 1'b1, cmd_ready);
    endtask

    task automatic read_check(input string name, input logic [ADDR_WIDTH-1:0] addr,
                              input fm_row_t exp_row);
        wait_idle(name);
        start_read(name, addr, exp_row);
        clock_cycle();
    endtask

    initial begin
        logic [ADDR_WIDTH-1:0] a;
        logic [ADDR_WIDTH-1:0] wr_list [$];
        fm_row_t               exp_row;
        int                    lo;
        int                    hi;
        int                    sel;
        seed       = 97247;
        checks     = 0;
        errors     = 0;
        clk        = 1'b0;
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        rd_en      = 1'b0;
        rd_req     = '0;
        rd_pending = 1'b0;
        rd_expect  = '0;
        rd_name    = "none";
        pend_lo    = 0;
        pend_hi    = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("reset cmd_ready", 1'b1, cmd_ready);
        check_bit("reset rd_valid", 1'b0, rd_valid);

        // preload every row at one write per cycle
        for (int i = 0; i < DEPTH; i++) begin
            check_bit("preload ready", 1'b1, cmd_ready);
            issue_cmd(make_cmd(OP_WRITE, i[ADDR_WIDTH-1:0], '0, pattern_row(i)), 1'b0);
        end

        // plain writes then read back
        for (int k = 0; k < 24; k++) begin
            a = pick_addr();
            issue_cmd(make_cmd(OP_WRITE, a, '0, random_row()), 1'b0);
            wr_list.push_back(a);
        end
        foreach (wr_list[k]) begin
            read_check("write readback", wr_list[k], shadow[wr_list[k]]);
        end

        // 1+3, 2+2, 3+1 in lanes 0 to 2
        issue_cmd(make_cmd(OP_WRITE, 8'd5, '0, {16'h3c00, 16'h4000, 16'h4200}), 1'b0);
        issue_cmd(make_cmd(OP_ADD_WRITE, 8'd5, '0, {16'h4200, 16'h4000, 16'h3c00}), 1'b0);
        verify_stall("directed add", 2);
        read_check("directed add", 8'd5, {16'h4400, 16'h4400, 16'h4400});

        // lane 0 cancels, lane 1 overflows, lane 2 adds a subnormal
        // to the smallest normal, which would change if the subnormal counted
        issue_cmd(make_cmd(OP_WRITE, 8'd9, '0, {16'h0123, 16'h7bff, 16'h4a3c}), 1'b0);
        issue_cmd(make_cmd(OP_ADD_WRITE, 8'd9, '0, {16'h0400, 16'h7bff, 16'hca3c}), 1'b0);
        read_check("cancel overflow subnormal", 8'd9, {16'h0400, 16'h7c00, 16'h0000});

        for (int k = 0; k < 200; k++) begin
            a = pick_addr();
            issue_cmd(make_cmd(OP_ADD_WRITE, a, '0, random_row()), 1'b1);
            read_check("random add", a, shadow[a]);
        end

        // zero fill keeps neighbors on both sides
        lo = 1 + $unsigned($random(seed)) % 200;
        hi = lo + 1 + $unsigned($random(seed)) % 40;
        issue_cmd(make_cmd(OP_ZERO_FILL, lo[ADDR_WIDTH-1:0], hi[ADDR_WIDTH-1:0], '0), 1'b0);
        verify_stall("zero fill", hi - lo);
        for (int k = lo - 1; k <= hi; k++) begin
            exp_row = (k >= lo && k < hi) ? fm_row_t'(0) : shadow[k];
            read_check("zero fill range", k[ADDR_WIDTH-1:0], exp_row);
        end

        // end not above start
        lo = 10 + $unsigned($random(seed)) % 240;
        hi = lo - $unsigned($random(seed)) % 6;
        issue_cmd(make_cmd(OP_ZERO_FILL, lo[ADDR_WIDTH-1:0], hi[ADDR_WIDTH-1:0], '0), 1'b0);
        verify_stall("empty fill", 0);
        for (int k = lo - 1; k <= lo + 1; k++) begin
            read_check("empty fill", k[ADDR_WIDTH-1:0], shadow[k]);
        end

        // back-to-back mix with reads during stalls
        for (int k = 0; k < 400; k++) begin
            sel = $unsigned($random(seed)) % 8;
            a   = pick_addr();
            if (sel < 3) begin
                issue_cmd(make_cmd(OP_WRITE, a, '0, random_row()), 1'b1);
            end else if (sel < 5) begin
                issue_cmd(make_cmd(OP_ADD_WRITE, a, '0, random_row()), 1'b1);
            end else if (sel == 5) begin
                hi = a + $unsigned($random(seed)) % 8;
                if (hi > DEPTH - 1) begin
                    hi = DEPTH - 1;
                end
                issue_cmd(make_cmd(OP_ZERO_FILL, a, hi[ADDR_WIDTH-1:0], '0), 1'b1);
            end else begin
                random_read("mix read");
                clock_cycle();
            end
        end

        // whole bank against the shadow
        for (int i = 0; i < DEPTH; i++) begin
            read_check("final sweep", i[ADDR_WIDTH-1:0], shadow[i]);
        end

        report_counts();
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+testbench
src/fm_buf_pkg.sv
src/fp16_lane_adder.sv
src/fill_addr_counter.sv
src/fm_row_bank.sv
src/fm_buf_ctrl.sv
src/fm_buf_top.sv
testbench/fm_buf_tb.sv

// File: Bender.yml
package:
  name: fm_buf

sources:
  - src/fm_buf_pkg.sv
  - src/fp16_lane_adder.sv
  - src/fill_addr_counter.sv
  - src/fm_row_bank.sv
  - src/fm_buf_ctrl.sv
  - src/fm_buf_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/fm_buf_tb.sv
